/* cluster_periph_xbar.f */
+incdir+logic
logic/periph_xbar_pkg.sv
logic/periph_req_steer.sv
logic/periph_rr_arbiter.sv
logic/periph_resp_router.sv
logic/cluster_periph_xbar.sv
testbench/tb_clock_gen.sv
testbench/tb_cluster_periph_xbar.sv

/* Bender.yml */
package:
  name: cluster_periph_xbar

export_include_dirs:
  - logic

sources:
  - logic/periph_xbar_pkg.sv
  - logic/periph_req_steer.sv
  - logic/periph_rr_arbiter.sv
  - logic/periph_resp_router.sv
  - logic/cluster_periph_xbar.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_cluster_periph_xbar.sv

/* testbench/tb_cluster_periph_xbar.sv */
// Testbench for the peripheral crossbar with behavioral target models
// Targets answer one cycle after each transfer and outputs are sampled on the falling edge
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module tb_cluster_periph_xbar;

  localparam int NB_INIT      = `PX_NB_INIT;
  localparam int NB_TGT       = `PX_NB_TARGETS;
  localparam int CLK_PERIOD   = 20;
  localparam int SEED         = 35513;
  localparam int N_RR         = 8;     // Per initiator
  localparam int N_BP         = 40;
  localparam int N_ROUNDS     = 12;
  localparam int PLANNED      = NB_INIT * N_RR + 128 + 24 + N_BP + N_ROUNDS * 4;
  localparam logic [31:0] RESP_KEY = 32'hA5C3_0F96;

  logic clk;
  logic rst_n;
  logic [NB_INIT-1:0]                            init_req;
  periph_xbar_pkg::periph_req_t [NB_INIT-1:0]    init_wdata;
  logic [NB_INIT-1:0]                            init_gnt;
  logic [NB_INIT-1:0]                            init_rvalid;
  periph_xbar_pkg::periph_resp_t [NB_INIT-1:0]   init_rdata;
  logic [NB_TGT-1:0]                             tgt_req;
  periph_xbar_pkg::periph_req_t [NB_TGT-1:0]     tgt_wdata;
  logic [NB_TGT-1:0]                             tgt_gnt;
  logic [NB_TGT-1:0]                             tgt_rvalid;
  periph_xbar_pkg::periph_resp_t [NB_TGT-1:0]    tgt_rdata;

  periph_xbar_pkg::periph_req_t pend_q [NB_INIT][$];   // Work per initiator
  logic               gnt_random;                      // Random target back-pressure
  int                 model_ptr [NB_TGT];
  logic [NB_INIT-1:0] resp_due;
  logic [31:0]        resp_addr [NB_INIT];
  int                 xfer_cnt;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(5)) u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cluster_periph_xbar u_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .init_req_i    (init_req),
    .init_wdata_i  (init_wdata),
    .init_gnt_o    (init_gnt),
    .init_rvalid_o (init_rvalid),
    .init_rdata_o  (init_rdata),
    .tgt_req_o     (tgt_req),
    .tgt_wdata_o   (tgt_wdata),
    .tgt_gnt_i     (tgt_gnt),
    .tgt_rvalid_i  (tgt_rvalid),
    .tgt_rdata_i   (tgt_rdata)
  );

  task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1, "Mismatch between DUT and expected value");
    end
  endtask

  // Expected target from the address map
  function automatic int ref_target(input logic [31:0] addr);
    logic own_base;
    int   tgt;
    own_base = (addr[31:24] == `PX_CLUSTER_BASE) ||
               (`PX_ALIAS_EN && (addr[31:24] == `PX_ALIAS_BASE));
    tgt = `PX_EXT_IDX;
    if (own_base && addr[23:20] >= `PX_PERIPH_LO && addr[23:20] <= `PX_PERIPH_HI) begin
      tgt = int'(addr[`PX_ROUTE_MSB:`PX_ROUTE_LSB]);
    end
    return tgt;
  endfunction

  // First requester at or after the pointer or -1 when there is none
  function automatic int ref_winner(input logic [NB_INIT-1:0] req, input int ptr);
    int idx;
    int win;
    win = -1;
    for (int k = 0; k < NB_INIT; k++) begin
      idx = (ptr + k) % NB_INIT;
      if (win < 0 && req[idx]) win = idx;
    end
    return win;
  endfunction

  function automatic logic [31:0] make_addr(input logic [7:0] base, input logic [3:0] region,
                                            input int tgt);
    logic [31:0] a;
    a          = $urandom;                 // Bits outside the decode stay random
    a[31:24]   = base;
    a[23:20]   = region;
    a[`PX_ROUTE_MSB:`PX_ROUTE_LSB] = tgt[1:0];
    return a;
  endfunction

  task automatic push_req(input int i, input logic [31:0] addr);
    periph_xbar_pkg::periph_req_t r;
    r.addr = addr;
    r.data = $urandom;
    r.id   = periph_xbar_pkg::init_id_t'($urandom);   // The DUT overwrites this junk id
    r.we_n = 1'($urandom_range(0, 1));
    r.be   = periph_xbar_pkg::be_t'($urandom);
    pend_q[i].push_back(r);
  endtask

  // All queues empty and the last responses seen
  task automatic wait_idle;
    int busy;
    do begin
      @(posedge clk);
      busy = 0;
      for (int i = 0; i < NB_INIT; i++) busy += pend_q[i].size();
    end while (busy != 0);
    repeat (2) @(posedge clk);
  endtask

  // Head of each initiator queue stays on the bus until granted
  initial begin : init_driver
    init_req   = '0;
    init_wdata = '0;
    forever begin
      @(posedge clk);
      #2;
      for (int i = 0; i < NB_INIT; i++) begin
        init_req[i]   = (pend_q[i].size() > 0);
        init_wdata[i] = init_req[i] ? pend_q[i][0] : '0;
      end
      @(negedge clk);
      for (int i = 0; i < NB_INIT; i++) begin
        if (init_req[i] && init_gnt[i]) void'(pend_q[i].pop_front());
      end
    end
  end

  // Target models
  initial begin : target_model
    logic [NB_TGT-1:0]            fire;
    periph_xbar_pkg::periph_req_t fire_req [NB_TGT];
    tgt_gnt    = '0;
    tgt_rvalid = '0;
    tgt_rdata  = '0;
    forever begin
      @(negedge clk);
      for (int t = 0; t < NB_TGT; t++) begin
        fire[t]     = tgt_req[t] & tgt_gnt[t];
        fire_req[t] = tgt_wdata[t];
      end
      @(posedge clk);
      #2;
      for (int t = 0; t < NB_TGT; t++) begin
        tgt_rvalid[t]     = fire[t];
        tgt_rdata[t]      = '0;
        if (fire[t]) begin
          tgt_rdata[t].data = fire_req[t].addr ^ RESP_KEY;
          tgt_rdata[t].id   = fire_req[t].id;
        end
        tgt_gnt[t] = gnt_random ? 1'($urandom_range(0, 1)) : 1'b1;
      end
    end
  end

  always @(negedge clk) begin : compare
    int                           tgt_of [NB_INIT];
    logic [NB_INIT-1:0]           col;
    logic [NB_INIT-1:0]           exp_gnt;
    periph_xbar_pkg::periph_req_t exp_req;
    int                           w;
    if (!rst_n) begin
      for (int t = 0; t < NB_TGT; t++) model_ptr[t] = 0;
      resp_due = '0;
    end else begin
      // Responses belong to last cycle's transfers
      for (int i = 0; i < NB_INIT; i++) begin
        check_eq(init_rvalid[i], resp_due[i], $sformatf("rvalid of initiator %0d", i));
        if (resp_due[i]) begin
          check_eq(init_rdata[i].data, resp_addr[i] ^ RESP_KEY, $sformatf("rdata %0d", i));
          check_eq(init_rdata[i].id, 1 << i, $sformatf("response id %0d", i));
          check_eq(init_rdata[i].opc, 1'b0, $sformatf("response opc %0d", i));
        end
      end
      for (int i = 0; i < NB_INIT; i++) tgt_of[i] = ref_target(init_wdata[i].addr);
      exp_gnt = '0;
      for (int t = 0; t < NB_TGT; t++) begin
        for (int i = 0; i < NB_INIT; i++) col[i] = init_req[i] && (tgt_of[i] == t);
        w = ref_winner(col, model_ptr[t]);
        check_eq(tgt_req[t], w >= 0, $sformatf("req of target %0d", t));
        if (w >= 0) begin
          exp_req    = init_wdata[w];
          exp_req.id = periph_xbar_pkg::init_id_t'(1 << w);
          check_eq(tgt_wdata[t], exp_req, $sformatf("payload at target %0d", t));
          exp_gnt[w] = tgt_gnt[t];
          if (tgt_gnt[t]) model_ptr[t] = (w + 1) % NB_INIT;
        end
      end
      check_eq(init_gnt, exp_gnt, "initiator grants");
      for (int i = 0; i < NB_INIT; i++) begin
        resp_due[i]  = init_req[i] & exp_gnt[i];
        resp_addr[i] = init_wdata[i].addr;
        if (resp_due[i]) xfer_cnt++;
      end
    end
  end

  initial begin : watchdog
    #(PLANNED * 20 * CLK_PERIOD);
    $display("Timeout: transfers still pending after %0d cycles", PLANNED * 20);
    $display("TEST FAILED");
    $fatal(1, "Simulation timed out");
  end

  initial begin : stimulus
    logic [7:0] other_base [6];
    int         perm_t [NB_INIT];
    int         perm_i [NB_INIT];
    int         j;
    int         tmp;
    void'($urandom(SEED));
    other_base = '{8'h00, 8'h11, 8'h1A, 8'h1C, 8'h20, 8'hFF};
    gnt_random = 1'b0;
    xfer_cnt   = 0;
    @(posedge rst_n);
    @(posedge clk);

    // All initiators hammer target 1 from pointer 0
    for (int n = 0; n < N_RR; n++) begin
      for (int i = 0; i < NB_INIT; i++) push_req(i, make_addr(`PX_CLUSTER_BASE, 4'h2, 1));
    end
    wait_idle();

    // Every region value and target index on the own base and then the alias
    for (int r = 0; r < 16; r++) begin
      for (int t = 0; t < NB_TGT; t++) push_req(0, make_addr(`PX_CLUSTER_BASE, r[3:0], t));
    end
    wait_idle();
    for (int r = 0; r < 16; r++) begin
      for (int t = 0; t < NB_TGT; t++) push_req(4, make_addr(`PX_ALIAS_BASE, r[3:0], t));
    end
    wait_idle();
    for (int b = 0; b < 6; b++) begin
      for (int k = 0; k < 4; k++) push_req(2, make_addr(other_base[b], 4'h2 + k[1], k % 2));
    end
    wait_idle();

    // Random target back-pressure with mixed initiators
    gnt_random = 1'b1;
    for (int n = 0; n < N_BP; n++) begin
      push_req($urandom_range(0, NB_INIT - 1),
               make_addr(`PX_CLUSTER_BASE, 4'h3, $urandom_range(0, NB_TGT - 1)));
    end
    wait_idle();
    gnt_random = 1'b0;

    // Four initiators on four targets answered in the same cycle
    for (int n = 0; n < N_ROUNDS; n++) begin
      for (int k = 0; k < NB_INIT; k++) begin
        perm_t[k] = k;
        perm_i[k] = k;
      end
      for (int k = NB_INIT - 1; k > 0; k--) begin
        j         = $urandom_range(0, k);
        tmp       = perm_i[k];
        perm_i[k] = perm_i[j];
        perm_i[j] = tmp;
        j         = $urandom_range(0, k) % NB_TGT;
        if (k < NB_TGT) begin
          tmp       = perm_t[k];
          perm_t[k] = perm_t[j];
          perm_t[j] = tmp;
        end
      end
      for (int k = 0; k < 4; k++) begin
        push_req(perm_i[k], make_addr(`PX_CLUSTER_BASE, 4'h2, perm_t[k]));
      end
      wait_idle();
    end

    check_eq(xfer_cnt, PLANNED, "number of transfers");
    $display("TEST OK");
    $finish;
  end

endmodule

/* testbench/tb_clock_gen.sv */
// Free-running clock and active-low reset for the testbench
// Reset is released 2 ns after the last reset edge
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS  = 20,
  parameter int unsigned RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #2 rst_n_o = 1'b1;                      // Same offset as the stimulus
  end

endmodule

/* logic/cluster_periph_xbar.sv */
// Crossbar from the cluster cores and master ports to the peripheral targets
// Request and response paths are combinational and only the arbiter pointers hold state
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module cluster_periph_xbar (
  input  logic                                              clk_i,
  input  logic                                              rst_n_i,
  input  logic [`PX_NB_INIT-1:0]                            init_req_i,
  input  periph_xbar_pkg::periph_req_t [`PX_NB_INIT-1:0]    init_wdata_i,
  output logic [`PX_NB_INIT-1:0]                            init_gnt_o,
  output logic [`PX_NB_INIT-1:0]                            init_rvalid_o,
  output periph_xbar_pkg::periph_resp_t [`PX_NB_INIT-1:0]   init_rdata_o,
  output logic [`PX_NB_TARGETS-1:0]                         tgt_req_o,
  output periph_xbar_pkg::periph_req_t [`PX_NB_TARGETS-1:0] tgt_wdata_o,
  input  logic [`PX_NB_TARGETS-1:0]                         tgt_gnt_i,
  input  logic [`PX_NB_TARGETS-1:0]                         tgt_rvalid_i,
  input  periph_xbar_pkg::periph_resp_t [`PX_NB_TARGETS-1:0] tgt_rdata_i
);

  periph_xbar_pkg::periph_req_t [`PX_NB_INIT-1:0] init_wdata_id;   // Payload with own ID
  logic [`PX_NB_INIT-1:0][`PX_NB_TARGETS-1:0]    req_mat;         // Row per initiator
  logic [`PX_NB_INIT-1:0][`PX_NB_TARGETS-1:0]    gnt_mat;

  for (genvar i = 0; i < `PX_NB_INIT; i++) begin : gen_init
    // Incoming id is replaced by the one-hot ID of this port
    assign init_wdata_id[i] = '{
      addr: init_wdata_i[i].addr,
      data: init_wdata_i[i].data,
      id:   periph_xbar_pkg::init_id_t'(1 << i),
      we_n: init_wdata_i[i].we_n,
      be:   init_wdata_i[i].be
    };

    periph_req_steer u_steer (
      .req_i     (init_req_i[i]),
      .addr_i    (init_wdata_i[i].addr),
      .tgt_req_o (req_mat[i]),
      .tgt_gnt_i (gnt_mat[i]),
      .gnt_o     (init_gnt_o[i])
    );

    // Every router sees all target responses
    periph_resp_router #(
      .INIT_IDX (i)
    ) u_router (
      .tgt_rvalid_i (tgt_rvalid_i),
      .tgt_rdata_i  (tgt_rdata_i),
      .rvalid_o     (init_rvalid_o[i]),
      .rdata_o      (init_rdata_o[i])
    );
  end

  for (genvar t = 0; t < `PX_NB_TARGETS; t++) begin : gen_tgt
    logic [`PX_NB_INIT-1:0] arb_req;
    logic [`PX_NB_INIT-1:0] arb_gnt;

    // Column t of the matrices belongs to this target
    for (genvar i = 0; i < `PX_NB_INIT; i++) begin : gen_col
      assign arb_req[i]    = req_mat[i][t];
      assign gnt_mat[i][t] = arb_gnt[i];
    end

    periph_rr_arbiter u_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (arb_req),
      .data_i  (init_wdata_id),
      .gnt_o   (arb_gnt),
      .req_o   (tgt_req_o[t]),
      .data_o  (tgt_wdata_o[t]),
      .gnt_i   (tgt_gnt_i[t])
    );
  end

endmodule

/* logic/periph_resp_router.sv */
// Response select for one initiator from the ID echoed by each target
// Two targets answering the same initiator at once lose the higher-numbered answer
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module periph_resp_router #(
  parameter int unsigned INIT_IDX = 0   // Bit of this initiator in the one-hot ID
) (
  input  logic [`PX_NB_TARGETS-1:0]                          tgt_rvalid_i,
  input  periph_xbar_pkg::periph_resp_t [`PX_NB_TARGETS-1:0] tgt_rdata_i,
  output logic                                               rvalid_o,
  output periph_xbar_pkg::periph_resp_t                      rdata_o
);

  logic [`PX_NB_TARGETS-1:0] hit;   // Targets answering this initiator
  periph_xbar_pkg::tgt_idx_t sel;

  always_comb begin
    for (int t = 0; t < `PX_NB_TARGETS; t++) begin
      hit[t] = tgt_rvalid_i[t] & tgt_rdata_i[t].id[INIT_IDX];
    end
  end

  // Scan down so the lowest hit is written last
  always_comb begin
    sel = '0;
    for (int t = `PX_NB_TARGETS - 1; t >= 0; t--) begin
      if (hit[t]) begin
        sel = periph_xbar_pkg::tgt_idx_t'(t);
      end
    end
  end

  assign rvalid_o = |hit;               // Same-cycle pulse from the target
  assign rdata_o  = tgt_rdata_i[sel];

endmodule

/* logic/periph_rr_arbiter.sv */
// Round-robin arbiter for one peripheral target
// Pointer moves only on a completed transfer so a stalled winner keeps its payload on the bus
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module periph_rr_arbiter (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  input  logic [`PX_NB_INIT-1:0]                         req_i,
  input  periph_xbar_pkg::periph_req_t [`PX_NB_INIT-1:0] data_i,
  output logic [`PX_NB_INIT-1:0]                         gnt_o,
  output logic                                           req_o,
  output periph_xbar_pkg::periph_req_t                   data_o,
  input  logic                                           gnt_i
);

  localparam int unsigned NB_INIT = `PX_NB_INIT;

  periph_xbar_pkg::init_idx_t rr_q;       // First initiator to look at
  periph_xbar_pkg::init_idx_t win_idx;
  periph_xbar_pkg::init_idx_t scan_idx;
  logic                       win_found;

  // Increment modulo the initiator count, which need not be a power of two
  function automatic periph_xbar_pkg::init_idx_t wrap_inc(
    input periph_xbar_pkg::init_idx_t idx
  );
    periph_xbar_pkg::init_idx_t nxt;
    if (idx == periph_xbar_pkg::init_idx_t'(NB_INIT - 1)) begin
      nxt = '0;
    end else begin
      nxt = idx + 1'b1;
    end
    return nxt;
  endfunction

  // Scan all initiators starting at the pointer
  always_comb begin
    win_found = 1'b0;
    win_idx   = rr_q;
    scan_idx  = rr_q;
    for (int unsigned k = 0; k < NB_INIT; k++) begin
      if (!win_found && req_i[scan_idx]) begin
        win_found = 1'b1;
        win_idx   = scan_idx;
      end
      scan_idx = wrap_inc(scan_idx);
    end
  end

  assign req_o  = win_found;
  assign data_o = data_i[win_idx];    // Winner payload straight to the target

  // Grant back to the winner only
  always_comb begin
    gnt_o          = '0;
    gnt_o[win_idx] = win_found & gnt_i;
  end

  // Next search starts just past the last winner
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (req_o && gnt_i) begin
      rr_q <= wrap_inc(win_idx);
    end
  end

endmodule

/* logic/periph_req_steer.sv */
// Address decode and request steering for one initiator
// Only bits 31:20 and the routing field take part in the decode
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module periph_req_steer (
  input  logic                      req_i,
  input  periph_xbar_pkg::addr_t    addr_i,
  output logic [`PX_NB_TARGETS-1:0] tgt_req_o,
  input  logic [`PX_NB_TARGETS-1:0] tgt_gnt_i,
  output logic                      gnt_o
);

  logic                      in_cluster;
  logic                      in_periph;
  periph_xbar_pkg::tgt_idx_t tgt_idx;

  // Access to this cluster through its own base or the alias
  assign in_cluster = (addr_i[31:24] == `PX_CLUSTER_BASE) ||
                      (`PX_ALIAS_EN && (addr_i[31:24] == `PX_ALIAS_BASE));

  // Peripheral window inside the cluster
  assign in_periph = (addr_i[23:20] >= `PX_PERIPH_LO) &&
                     (addr_i[23:20] <= `PX_PERIPH_HI);

  always_comb begin
    if (in_cluster && in_periph) begin
      tgt_idx = addr_i[`PX_ROUTE_MSB:`PX_ROUTE_LSB];         // Local peripheral
    end else begin
      tgt_idx = periph_xbar_pkg::tgt_idx_t'(`PX_EXT_IDX);    // Leaves the cluster
    end
  end

  // Only the decoded target sees the request
  always_comb begin
    tgt_req_o          = '0;
    tgt_req_o[tgt_idx] = req_i;
  end

  // Grant of the decoded target goes back to the initiator
  assign gnt_o = tgt_gnt_i[tgt_idx];

endmodule

/* logic/periph_xbar_pkg.sv */
// Payload types of the peripheral crossbar
// The id field is one-hot with one bit per initiator
`include "periph_xbar_settings.svh"

package periph_xbar_pkg;

  typedef logic [`PX_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`PX_DATA_WIDTH-1:0] data_t;
  typedef logic [`PX_BE_WIDTH-1:0]   be_t;

  // Binary target index, as carried in the routing field
  typedef logic [$clog2(`PX_NB_TARGETS)-1:0] tgt_idx_t;

  // Binary initiator index for the round-robin pointer
  typedef logic [$clog2(`PX_NB_INIT)-1:0] init_idx_t;

  typedef logic [`PX_NB_INIT-1:0] init_id_t;  // One-hot source ID

  // Request towards a peripheral
  typedef struct packed {
    addr_t    addr;
    data_t    data;
    init_id_t id;
    logic     we_n;  // Low for a write
    be_t      be;
  } periph_req_t;

  // Response from a peripheral
  typedef struct packed {
    data_t    data;
    init_id_t id;    // Echo of the request id
    logic     opc;   // Error flag from the target
  } periph_resp_t;

endpackage

/* logic/periph_xbar_settings.svh */
// Crossbar sizes, widths and the peripheral address map
// Decode assumes 32-bit addresses and at least two initiators and two targets
`ifndef PERIPH_XBAR_SETTINGS_SVH
`define PERIPH_XBAR_SETTINGS_SVH

// Initiators
`define PX_NB_CORES     4
`define PX_NB_MPERIPHS  1                  // Extra master ports after the cores
`define PX_NB_INIT      (`PX_NB_CORES + `PX_NB_MPERIPHS)

// Targets and bus widths
`define PX_NB_TARGETS   4
`define PX_ADDR_WIDTH   32
`define PX_DATA_WIDTH   32
`define PX_BE_WIDTH     (`PX_DATA_WIDTH / 8)

// Address map
`define PX_CLUSTER_BASE 8'h10              // Bits 31:24 of this cluster
`define PX_ALIAS_EN     1'b1
`define PX_ALIAS_BASE   8'h1B              // Second accepted value of bits 31:24
`define PX_PERIPH_LO    4'h2               // Peripheral region in bits 23:20
`define PX_PERIPH_HI    4'h3
`define PX_ROUTE_LSB    16                 // Must be as wide as the target index
`define PX_ROUTE_MSB    17
`define PX_EXT_IDX      3                  // Target for all non-local accesses

`endif
